// ==== common/midiPackage.sv ====
// shared constants and encodings for the MIDI receiver.
// covers serial bit timing, message and FIFO sizes, and the
// state, command and register address enums.
package midiPackage;

    // serial timing in clock cycles.
    localparam int BIT_PERIOD = 32;
    localparam int HALF_BIT = BIT_PERIOD / 2;
    localparam int COUNTER_WIDTH = $clog2(BIT_PERIOD);

    // status, data1 and data2 packed high to low.
    localparam int MESSAGE_WIDTH = 24;

    localparam int FIFO_DEPTH = 8;
    localparam int POINTER_WIDTH = $clog2(FIFO_DEPTH);
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rxState;

    typedef enum logic [1:0] {
        WAIT_STATUS,
        WAIT_DATA1,
        WAIT_DATA2
    } parserState;

    // high nibble of a channel voice status byte.
    typedef enum logic [3:0] {
        NOTE_OFF         = 4'h8,
        NOTE_ON          = 4'h9,
        POLY_PRESSURE    = 4'hA,
        CONTROL_CHANGE   = 4'hB,
        PROGRAM_CHANGE   = 4'hC,
        CHANNEL_PRESSURE = 4'hD,
        PITCH_BEND       = 4'hE
    } midiCommand;

    typedef enum logic [1:0] {
        STATUS_REG  = 2'd0,
        MESSAGE_REG = 2'd1,
        CONTROL_REG = 2'd2
    } registerAddress;

endpackage

// ==== uartReceiver/uartDeserializer.sv ====
// UART deserializer for the MIDI input pin.
// synchronizes rx, times every bit with its own cycle counter and
// shifts in 8N1 frames LSB first. a good stop bit yields a byte
// strobe, a low stop bit yields a frame error strobe.
module uartDeserializer (
    input  logic       clock,
    input  logic       reset,
    input  logic       rx,
    input  logic       enable,
    output logic       byteValid,
    output logic [7:0] rxByte,
    output logic       frameError
);
    import midiPackage::*;

    rxState state;
    logic rxMeta;
    logic rxSync;
    logic [COUNTER_WIDTH-1:0] cycleCount;
    logic [COUNTER_WIDTH-1:0] bound;
    logic sampleNow;
    logic [2:0] bitIndex;
    logic [7:0] shiftReg;

    // two-flop synchronizer.
    // the line idles high.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rx;
            rxSync <= rxMeta;
        end
    end

    // start bit is checked at half a bit, everything else a full bit apart.
    assign bound = (state == START) ? COUNTER_WIDTH'(HALF_BIT - 1)
                                    : COUNTER_WIDTH'(BIT_PERIOD - 1);
    assign sampleNow = (cycleCount == bound);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            cycleCount <= '0;
            bitIndex <= '0;
            byteValid <= 1'b0;
            frameError <= 1'b0;
        end else begin
            byteValid <= 1'b0;
            frameError <= 1'b0;
            if (!enable) begin
                state <= IDLE;
                cycleCount <= '0;
                bitIndex <= '0;
            end else begin
                if (state == IDLE || sampleNow) begin
                    cycleCount <= '0;
                end else begin
                    cycleCount <= cycleCount + 1'b1;
                end
                case (state)
                    IDLE: begin
                        bitIndex <= '0;
                        if (!rxSync) begin
                            state <= START;
                        end
                    end
                    START: begin
                        // a start bit gone high by mid-bit is a glitch.
                        if (sampleNow) begin
                            state <= rxSync ? IDLE : DATA;
                        end
                    end
                    DATA: begin
                        if (sampleNow) begin
                            bitIndex <= bitIndex + 1'b1;
                            if (bitIndex == 3'd7) begin
                                state <= STOP;
                            end
                        end
                    end
                    STOP: begin
                        if (sampleNow) begin
                            byteValid <= rxSync;
                            frameError <= !rxSync;
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // data path.
    always_ff @(posedge clock) begin
        if (enable && sampleNow) begin
            if (state == DATA) begin
                shiftReg <= {rxSync, shiftReg[7:1]};
            end
            if (state == STOP && rxSync) begin
                rxByte <= shiftReg;
            end
        end
    end

    // a frame ends in exactly one of the two outcomes.
    byteOrErrorOnly: assert property (
        @(posedge clock) disable iff (reset)
        !(byteValid && frameError)
    );

endmodule

// ==== midiParser/midiParser.sv ====
// MIDI byte parser.
// assembles channel voice messages from the received byte stream
// with running status. system common bytes cancel the running status
// and realtime bytes pass by without effect.
module midiParser (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  byteValid,
    input  logic [7:0]                            rxByte,
    output logic                                  messageValid,
    output logic [midiPackage::MESSAGE_WIDTH-1:0] message
);
    import midiPackage::*;

    parserState state;
    midiCommand command;
    logic [7:0] runningStatus;
    logic [7:0] data1;
    logic isRealtime;
    logic isSystemStatus;
    logic isChannelStatus;
    logic isData;
    logic haveStatus;
    logic shortMessage;
    logic completeShort;
    logic completeLong;

    // byte classes.
    assign isRealtime = (rxByte >= 8'hF8);
    assign isSystemStatus = (rxByte[7:4] == 4'hF) && !isRealtime;
    assign isChannelStatus = rxByte[7] && (rxByte[7:4] != 4'hF);
    assign isData = !rxByte[7];

    // cleared running status has its MSB low.
    assign haveStatus = runningStatus[7];
    assign command = midiCommand'(runningStatus[7:4]);
    assign shortMessage = (command == PROGRAM_CHANGE) || (command == CHANNEL_PRESSURE);

    // a data byte outside WAIT_DATA2 acts as data1.
    assign completeShort = byteValid && isData && haveStatus
                           && (state != WAIT_DATA2) && shortMessage;
    assign completeLong = byteValid && isData && (state == WAIT_DATA2);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= WAIT_STATUS;
            runningStatus <= '0;
            messageValid <= 1'b0;
        end else begin
            messageValid <= completeShort || completeLong;
            if (byteValid) begin
                if (isChannelStatus) begin
                    runningStatus <= rxByte;
                    state <= WAIT_DATA1;
                end else if (isSystemStatus) begin
                    runningStatus <= '0;
                    state <= WAIT_STATUS;
                end else if (isData) begin
                    case (state)
                        WAIT_STATUS, WAIT_DATA1: begin
                            // orphan data bytes are dropped.
                            if (haveStatus) begin
                                state <= shortMessage ? WAIT_STATUS : WAIT_DATA2;
                            end
                        end
                        WAIT_DATA2: state <= WAIT_STATUS;
                        default: state <= WAIT_STATUS;
                    endcase
                end
            end
        end
    end

    // message assembly.
    always_ff @(posedge clock) begin
        if (byteValid && isData) begin
            if (state == WAIT_DATA2) begin
                message <= {runningStatus, data1, rxByte};
            end else if (shortMessage) begin
                message <= {runningStatus, rxByte, 8'h00};
            end else begin
                data1 <= rxByte;
            end
        end
    end

    // every emitted message starts with a real status byte.
    statusMsbSet: assert property (
        @(posedge clock) disable iff (reset)
        messageValid |-> message[MESSAGE_WIDTH-1]
    );

endmodule

// ==== source/messageFifo.sv ====
// message FIFO between the parser and the host interface.
// circular buffer with an occupancy count, and a push into a
// full buffer is dropped and flagged as overrun.
module messageFifo (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  push,
    input  logic [midiPackage::MESSAGE_WIDTH-1:0] pushMessage,
    input  logic                                  pop,
    output logic [midiPackage::MESSAGE_WIDTH-1:0] headMessage,
    output logic                                  empty,
    output logic                                  full,
    output logic                                  overrun
);
    import midiPackage::*;

    logic [MESSAGE_WIDTH-1:0] storage [FIFO_DEPTH];
    logic [POINTER_WIDTH-1:0] readPointer;
    logic [POINTER_WIDTH-1:0] writePointer;
    logic [COUNT_WIDTH-1:0] count;
    logic doPush;
    logic doPop;

    assign empty = (count == '0);
    assign full = (count == COUNT_WIDTH'(FIFO_DEPTH));
    assign doPush = push && !full;
    assign doPop = pop && !empty;
    assign headMessage = storage[readPointer];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            readPointer <= '0;
            writePointer <= '0;
            count <= '0;
            overrun <= 1'b0;
        end else begin
            overrun <= push && full;
            if (doPush) begin
                writePointer <= writePointer + 1'b1;
            end
            if (doPop) begin
                readPointer <= readPointer + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (doPush) begin
            storage[writePointer] <= pushMessage;
        end
    end

    // host side must check empty before popping.
    noPopWhenEmpty: assert property (
        @(posedge clock) disable iff (reset) pop |-> !empty
    );

    countInRange: assert property (
        @(posedge clock) disable iff (reset) count <= COUNT_WIDTH'(FIFO_DEPTH)
    );

endmodule

// ==== source/wishboneSlave.sv ====
// Wishbone classic slave for the MIDI receiver.
// status, message pop and control registers, saturating overrun
// and frame error counters, and the receive interrupt.
module wishboneSlave (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  wbCyc,
    input  logic                                  wbStb,
    input  logic                                  wbWe,
    input  logic [1:0]                            wbAdr,
    input  logic [31:0]                           wbDatIn,
    output logic [31:0]                           wbDatOut,
    output logic                                  wbAck,
    input  logic [midiPackage::MESSAGE_WIDTH-1:0] headMessage,
    input  logic                                  empty,
    input  logic                                  full,
    input  logic                                  overrun,
    input  logic                                  frameError,
    output logic                                  pop,
    output logic                                  enable,
    output logic                                  irq
);
    import midiPackage::*;

    registerAddress address;
    logic request;
    logic [7:0] overrunCount;
    logic [7:0] frameErrorCount;
    logic clearCounters;

    assign address = registerAddress'(wbAdr);
    // one request per strobe, so a held strobe is not acked twice.
    assign request = wbCyc && wbStb && !wbAck;
    assign clearCounters = request && wbWe && (address == CONTROL_REG) && wbDatIn[1];
    assign irq = enable && !empty;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wbAck <= 1'b0;
            pop <= 1'b0;
            enable <= 1'b1;
            overrunCount <= '0;
            frameErrorCount <= '0;
        end else begin
            wbAck <= request;
            pop <= request && !wbWe && (address == MESSAGE_REG) && !empty;
            if (request && wbWe && (address == CONTROL_REG)) begin
                enable <= wbDatIn[0];
            end
            // saturating counters.
            if (clearCounters) begin
                overrunCount <= '0;
                frameErrorCount <= '0;
            end else begin
                if (overrun && overrunCount != 8'hFF) begin
                    overrunCount <= overrunCount + 1'b1;
                end
                if (frameError && frameErrorCount != 8'hFF) begin
                    frameErrorCount <= frameErrorCount + 1'b1;
                end
            end
        end
    end

    // read data is latched with the ack.
    always_ff @(posedge clock) begin
        if (request) begin
            case (address)
                STATUS_REG:  wbDatOut <= {8'h00, frameErrorCount, overrunCount, 6'b0, full, !empty};
                MESSAGE_REG: wbDatOut <= empty ? 32'h0 : {8'h00, headMessage};
                CONTROL_REG: wbDatOut <= {31'b0, enable};
                default:     wbDatOut <= 32'h0;
            endcase
        end
    end

    ackFollowsRequest: assert property (
        @(posedge clock) disable iff (reset) wbAck |-> $past(wbCyc && wbStb)
    );

endmodule

// ==== source/midiReceiver.sv ====
// MIDI input port top level.
// serial deserializer, message parser, message FIFO and the
// Wishbone host interface.
module midiReceiver (
    input  logic        clock,
    input  logic        reset,
    input  logic        rx,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [1:0]  wbAdr,
    input  logic [31:0] wbDatIn,
    output logic [31:0] wbDatOut,
    output logic        wbAck,
    output logic        irq
);
    import midiPackage::*;

    logic byteValid;
    logic [7:0] rxByte;
    logic frameError;
    logic messageValid;
    logic [MESSAGE_WIDTH-1:0] message;
    logic [MESSAGE_WIDTH-1:0] headMessage;
    logic empty;
    logic full;
    logic overrun;
    logic pop;
    logic enable;

    uartDeserializer uartDeserializer_i (
        .clock, .reset, .rx, .enable, .byteValid, .rxByte, .frameError
    );

    midiParser midiParser_i (
        .clock, .reset, .byteValid, .rxByte, .messageValid, .message
    );

    messageFifo messageFifo_i (
        .clock, .reset, .push(messageValid), .pushMessage(message), .pop,
        .headMessage, .empty, .full, .overrun
    );

    wishboneSlave wishboneSlave_i (
        .clock, .reset, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatIn, .wbDatOut, .wbAck,
        .headMessage, .empty, .full, .overrun, .frameError, .pop, .enable, .irq
    );

endmodule

// ==== tests/midiTasks.svh ====
// serial frame and Wishbone bus tasks for the MIDI receiver testbench.
// relies on the DUT signals and error counters of the including module.
`ifndef MIDI_TASKS_SVH
`define MIDI_TASKS_SVH

// waits for rising edges, then steps just past the last one.
task automatic holdCycles(input int cycles);
    repeat (cycles) @(posedge clock);
    #1;
endtask

// one 8N1 frame plus an idle bit, LSB first.
task automatic sendByte(input logic [7:0] value, input logic stopBit);
    rx = 1'b0;
    holdCycles(BIT_PERIOD);
    for (int i = 0; i < 8; i++) begin
        rx = value[i];
        holdCycles(BIT_PERIOD);
    end
    rx = stopBit;
    holdCycles(BIT_PERIOD);
    rx = 1'b1;
    holdCycles(BIT_PERIOD);
endtask

task automatic wbRead(input logic [1:0] address, output logic [31:0] data);
    int waited;
    waited = 0;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = 1'b0;
    wbAdr = address;
    holdCycles(1);
    while (!wbAck && waited < ACK_TIMEOUT) begin
        holdCycles(1);
        waited++;
    end
    if (wbAck) begin
        data = wbDatOut;
    end else begin
        otherErrors++;
        $display("no Wishbone acknowledge for a read of address %0d", address);
        data = '0;
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    holdCycles(1);
endtask

task automatic wbWrite(input logic [1:0] address, input logic [31:0] data);
    int waited;
    waited = 0;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = 1'b1;
    wbAdr = address;
    wbDatIn = data;
    holdCycles(1);
    while (!wbAck && waited < ACK_TIMEOUT) begin
        holdCycles(1);
        waited++;
    end
    if (!wbAck) begin
        otherErrors++;
        $display("no Wishbone acknowledge for a write of address %0d", address);
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    holdCycles(1);
endtask

// polls the status register, then pops the head message.
task automatic readMessage(output logic [31:0] message);
    logic [31:0] status;
    int polls;
    polls = 0;
    wbRead(STATUS_REG, status);
    while (!status[0] && polls < POLL_LIMIT) begin
        wbRead(STATUS_REG, status);
        polls++;
    end
    if (status[0]) begin
        wbRead(MESSAGE_REG, message);
    end else begin
        otherErrors++;
        $display("no message arrived in the FIFO within %0d polls", POLL_LIMIT);
        message = '0;
    end
endtask

`endif

// ==== tests/midiReceiverTb.sv ====
// testbench for the MIDI receiver.
// sends serial frames into rx, then reads the Wishbone registers and
// checks messages, status bits, counters and the interrupt.
module midiReceiverTb;
    import midiPackage::*;

    localparam int CLOCK_PERIOD = 40;
    // start, eight data, stop and one idle bit per frame.
    localparam int BITS_PER_FRAME = 11;
    localparam int TOTAL_BYTES = 43;
    localparam int MARGIN_CYCLES = 2000;
    localparam int WATCHDOG_TIME =
        (TOTAL_BYTES * BITS_PER_FRAME * BIT_PERIOD + MARGIN_CYCLES) * CLOCK_PERIOD;
    localparam int ACK_TIMEOUT = 16;
    localparam int POLL_LIMIT = 64;

    logic clock;
    logic reset;
    logic rx;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [1:0] wbAdr;
    logic [31:0] wbDatIn;
    logic [31:0] wbDatOut;
    logic wbAck;
    logic irq;

    integer seed;
    int valueErrors;
    int otherErrors;
    int checkCount;
    logic [31:0] readData;
    logic [7:0] data [4];
    logic [31:0] expectedQueue [$];

    midiReceiver midiReceiver_i (
        .clock, .reset, .rx, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatIn,
        .wbDatOut, .wbAck, .irq
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    `include "midiTasks.svh"

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected)
        else begin
            valueErrors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // data bytes keep their MSB low.
    function automatic logic [7:0] nextDataByte();
        logic [31:0] randomValue;
        randomValue = $random(seed);
        return {1'b0, randomValue[6:0]};
    endfunction

    // register view of a message: status, data1, data2.
    function automatic logic [31:0] packMessage(input logic [7:0] status,
                                                input logic [7:0] data1,
                                                input logic [7:0] data2);
        return {8'h00, status, data1, data2};
    endfunction

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before the tests finished");
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors + 1);
        $display("test failed");
        $finish;
    end

    initial begin
        seed = 8;
        clock = 1'b0;
        reset = 1'b1;
        rx = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatIn = '0;
        valueErrors = 0;
        otherErrors = 0;
        checkCount = 0;
        holdCycles(5);
        reset = 1'b0;
        holdCycles(2);

        // single note on, irq raised while queued.
        data[0] = nextDataByte();
        data[1] = nextDataByte();
        sendByte(8'h93, 1'b1);
        sendByte(data[0], 1'b1);
        sendByte(data[1], 1'b1);
        checkValue("irq", 32'd1, {31'b0, irq});
        readMessage(readData);
        checkValue("wbDatOut", packMessage(8'h93, data[0], data[1]), readData);
        checkValue("irq", 32'd0, {31'b0, irq});

        // running status shared by two messages.
        for (int i = 0; i < 4; i++) begin
            data[i] = nextDataByte();
        end
        sendByte(8'hB3, 1'b1);
        for (int i = 0; i < 4; i++) begin
            sendByte(data[i], 1'b1);
        end
        readMessage(readData);
        checkValue("wbDatOut", packMessage(8'hB3, data[0], data[1]), readData);
        readMessage(readData);
        checkValue("wbDatOut", packMessage(8'hB3, data[2], data[3]), readData);

        // one data byte commands.
        data[0] = nextDataByte();
        data[1] = nextDataByte();
        sendByte(8'hC2, 1'b1);
        sendByte(data[0], 1'b1);
        sendByte(8'hD2, 1'b1);
        sendByte(data[1], 1'b1);
        readMessage(readData);
        checkValue("wbDatOut", packMessage(8'hC2, data[0], 8'h00), readData);
        readMessage(readData);
        checkValue("wbDatOut", packMessage(8'hD2, data[1], 8'h00), readData);

        // realtime byte in the middle, then a system status byte.
        data[0] = nextDataByte();
        data[1] = nextDataByte();
        sendByte(8'h91, 1'b1);
        sendByte(data[0], 1'b1);
        sendByte(8'hF8, 1'b1);
        sendByte(data[1], 1'b1);
        readMessage(readData);
        checkValue("wbDatOut", packMessage(8'h91, data[0], data[1]), readData);
        // two data bytes would complete a note on if the status survived.
        sendByte(8'hF0, 1'b1);
        sendByte(nextDataByte(), 1'b1);
        sendByte(nextDataByte(), 1'b1);
        wbRead(STATUS_REG, readData);
        checkValue("wbDatOut", 32'h0000_0000, readData);

        // low stop bit counts as a frame error.
        // a delivered byte would complete the program change.
        sendByte(8'hC5, 1'b1);
        sendByte(8'h45, 1'b0);
        wbRead(STATUS_REG, readData);
        checkValue("wbDatOut", 32'h0001_0000, readData);
        wbWrite(CONTROL_REG, 32'h0000_0003);
        wbRead(STATUS_REG, readData);
        checkValue("wbDatOut", 32'h0000_0000, readData);

        // nine messages into eight slots.
        sendByte(8'h95, 1'b1);
        for (int k = 0; k < 9; k++) begin
            data[0] = nextDataByte();
            data[1] = nextDataByte();
            sendByte(data[0], 1'b1);
            sendByte(data[1], 1'b1);
            expectedQueue.push_back(packMessage(8'h95, data[0], data[1]));
        end
        wbRead(STATUS_REG, readData);
        checkValue("wbDatOut", 32'h0000_0103, readData);
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            readMessage(readData);
            checkValue("wbDatOut", expectedQueue.pop_front(), readData);
        end
        wbRead(STATUS_REG, readData);
        checkValue("wbDatOut", 32'h0000_0100, readData);

        // receiver disabled.
        wbWrite(CONTROL_REG, 32'h0000_0000);
        sendByte(8'h95, 1'b1);
        sendByte(nextDataByte(), 1'b1);
        sendByte(nextDataByte(), 1'b1);
        wbRead(STATUS_REG, readData);
        checkValue("wbDatOut", 32'h0000_0100, readData);
        checkValue("irq", 32'd0, {31'b0, irq});

        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checkCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/midiPackage.sv
uartReceiver/uartDeserializer.sv
midiParser/midiParser.sv
source/messageFifo.sv
source/wishboneSlave.sv
source/midiReceiver.sv
+incdir+tests
tests/midiReceiverTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MIDI receiver testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=simulation.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --top-module midiReceiverTb \
    -f files.f -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/VmidiReceiverTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
